// File: Makefile
SRCS := $(shell grep -v '^+' src.f) design/gui_settings.svh

.PHONY: all run clean

all: obj_dir/Vgui_tb

obj_dir/Vgui_tb: src.f $(SRCS)
	verilator --binary --timing --assert --top-module gui_tb -f src.f

run: obj_dir/Vgui_tb
	@out="$$(./obj_dir/Vgui_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir

// File: design/bmp_pixel_stream.sv
// bitmap pixel stream: shared bitmap shift register, draw window and pixel colour
`timescale 1ns/10ps
`default_nettype none

`include "gui_settings.svh"

module bmp_pixel_stream (
    input  wire                  clk,
    input  wire                  arstn,
    input  wire gui_pkg::slot_t  slot,
    input  wire                  active,
    input  wire                  load,
    input  wire                  cnext,
    input  wire                  start_state,
    output gui_pkg::coord_t      xstart,
    output gui_pkg::coord_t      xend,
    output gui_pkg::coord_t      ystart,
    output gui_pkg::coord_t      yend,
    output gui_pkg::color_t      color
);
    import gui_pkg::*;

    localparam coord_t BMP_X0 = coord_t'(`GUI_BTN_X + `GUI_BMP_XOFS);
    localparam coord_t BMP_X1 = coord_t'(`GUI_BTN_X + `GUI_BMP_XOFS + `GUI_BMP_W - 1);

    bmp_t   bmp_sel;
    bmp_t   bmpreg;
    coord_t bmp_y0;

    always_comb begin
        case (slot)
            SLOT_START: begin
                bmp_sel = start_state ? BMP_START_GO : BMP_START_PAUSE;
                bmp_y0  = coord_t'(`GUI_START_Y + `GUI_BMP_YOFS);
            end
            SLOT_LEFT: begin
                bmp_sel = BMP_LEFT;
                bmp_y0  = coord_t'(`GUI_LEFT_Y + `GUI_BMP_YOFS);
            end
            SLOT_RIGHT: begin
                bmp_sel = BMP_RIGHT;
                bmp_y0  = coord_t'(`GUI_RIGHT_Y + `GUI_BMP_YOFS);
            end
            default: begin
                bmp_sel = '0;
                bmp_y0  = '0;
            end
        endcase
    end

    // one register serves every button
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn)
            bmpreg <= '0;
        else if (load)
            bmpreg <= bmp_sel;
        else if (cnext)
            bmpreg <= bmpreg << 1; // next pixel into bit 0
    end

    assign xstart = active ? BMP_X0 : '0;
    assign xend   = active ? BMP_X1 : '0;
    assign ystart = active ? bmp_y0 : '0;
    assign yend   = active ? coord_t'(bmp_y0 + coord_t'(`GUI_BMP_H - 1)) : '0;

    assign color = !active  ? '0 :
                   bmpreg[0] ? color_t'(`GUI_FG_COLOR) : color_t'(`GUI_BG_COLOR);

endmodule

`default_nettype wire

// File: design/button_touch.sv
// button touch: press detection, rectangle hit tests, start toggle and redraw pending flags
`timescale 1ns/10ps
`default_nettype none

`include "gui_settings.svh"

module button_touch (
    input  wire                  clk,
    input  wire                  arstn,
    input  wire                  touch,
    input  wire gui_pkg::coord_t touchx, // screen coordinates
    input  wire gui_pkg::coord_t touchy,
    input  wire                  start_rst,
    input  wire                  start_ack,
    input  wire                  left_ack,
    input  wire                  right_ack,
    output logic                 start_state, // 0 pause, 1 go
    output logic                 left_touched,
    output logic                 right_touched,
    output logic                 start_pend,
    output logic                 left_pend,
    output logic                 right_pend
);
    import gui_pkg::*;

    logic touch_q;
    logic press;
    logic hit_start;
    logic hit_left;
    logic hit_right;

    // inclusive bounds, shared column
    function automatic logic in_rect(coord_t x, coord_t y, coord_t top);
        logic in_x;
        logic in_y;
        in_x = (x >= coord_t'(`GUI_BTN_X)) && (x <= coord_t'(`GUI_BTN_X + `GUI_BTN_W - 1));
        in_y = (y >= top) && (y <= coord_t'(top + `GUI_BTN_H - 1));
        return in_x && in_y;
    endfunction

    assign press     = touch & ~touch_q; // rising edge of touch
    assign hit_start = press && in_rect(touchx, touchy, coord_t'(`GUI_START_Y));
    assign hit_left  = press && in_rect(touchx, touchy, coord_t'(`GUI_LEFT_Y));
    assign hit_right = press && in_rect(touchx, touchy, coord_t'(`GUI_RIGHT_Y));

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            touch_q       <= 1'b0;
            left_touched  <= 1'b0;
            right_touched <= 1'b0;
        end else begin
            touch_q       <= touch;
            left_touched  <= hit_left;
            right_touched <= hit_right;
        end
    end

    // external clear wins over a press
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            start_state <= 1'b0;
            start_pend  <= 1'b1;
        end else if (start_rst) begin
            start_state <= 1'b0;
            start_pend  <= 1'b1;
        end else if (hit_start) begin
            start_state <= ~start_state;
            start_pend  <= 1'b1;
        end else if (start_ack) begin
            start_pend  <= 1'b0;
        end
    end

    // arrows only need their first draw
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            left_pend  <= 1'b1;
            right_pend <= 1'b1;
        end else begin
            if (left_ack)
                left_pend <= 1'b0;
            if (right_ack)
                right_pend <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/gui.sv
// gui top: touch buttons, draw sequencer and shared bitmap stream for the tft panel
`timescale 1ns/10ps
`default_nettype none

module gui (
    input  wire                  clk,
    input  wire                  arstn,
    input  wire                  touch,
    input  wire gui_pkg::coord_t touchx,
    input  wire gui_pkg::coord_t touchy,
    input  wire                  draw,
    input  wire                  cnext,
    input  wire                  tft_done,
    input  wire                  start_rst,
    output logic                 update, // some button needs a redraw
    output logic                 tft_draw,
    output logic                 drawdone,
    output gui_pkg::coord_t      xstart,
    output gui_pkg::coord_t      xend,
    output gui_pkg::coord_t      ystart,
    output gui_pkg::coord_t      yend,
    output gui_pkg::color_t      color,
    output logic                 start_state,
    output logic                 left_touched,
    output logic                 right_touched
);
    import gui_pkg::*;

    logic  start_pend;
    logic  left_pend;
    logic  right_pend;
    logic  start_ack;
    logic  left_ack;
    logic  right_ack;
    logic  load;
    logic  active;
    slot_t slot;

    button_touch touch0 (
        .clk(clk), .arstn(arstn),
        .touch(touch), .touchx(touchx), .touchy(touchy),
        .start_rst(start_rst),
        .start_ack(start_ack), .left_ack(left_ack), .right_ack(right_ack),
        .start_state(start_state),
        .left_touched(left_touched), .right_touched(right_touched),
        .start_pend(start_pend), .left_pend(left_pend), .right_pend(right_pend)
    );

    gui_draw_seq seq0 (
        .clk(clk), .arstn(arstn),
        .draw(draw), .tft_done(tft_done),
        .start_pend(start_pend), .left_pend(left_pend), .right_pend(right_pend),
        .tft_draw(tft_draw), .drawdone(drawdone),
        .start_ack(start_ack), .left_ack(left_ack), .right_ack(right_ack),
        .load(load), .slot(slot), .active(active)
    );

    bmp_pixel_stream stream0 (
        .clk(clk), .arstn(arstn),
        .slot(slot), .active(active), .load(load), .cnext(cnext),
        .start_state(start_state),
        .xstart(xstart), .xend(xend), .ystart(ystart), .yend(yend),
        .color(color)
    );

    assign update = start_pend | left_pend | right_pend;

endmodule

`default_nettype wire

// File: design/gui_draw_seq.sv
// gui draw sequencer: walks the buttons on a draw request and hands pending ones to the display
`timescale 1ns/10ps
`default_nettype none

module gui_draw_seq (
    input  wire             clk,
    input  wire             arstn,
    input  wire             draw,
    input  wire             tft_done,
    input  wire             start_pend,
    input  wire             left_pend,
    input  wire             right_pend,
    output logic            tft_draw,
    output logic            drawdone,
    output logic            start_ack,
    output logic            left_ack,
    output logic            right_ack,
    output logic            load,
    output gui_pkg::slot_t  slot,
    output logic            active
);
    import gui_pkg::*;

    seq_state_t state;
    seq_state_t after;
    logic       cur_pend;
    logic       grant;

    // per slot decode
    always_comb begin
        case (state)
            SEQ_START: begin
                slot     = SLOT_START;
                cur_pend = start_pend;
                after    = SEQ_LEFT;
            end
            SEQ_LEFT: begin
                slot     = SLOT_LEFT;
                cur_pend = left_pend;
                after    = SEQ_RIGHT;
            end
            SEQ_RIGHT: begin
                slot     = SLOT_RIGHT;
                cur_pend = right_pend;
                after    = SEQ_IDLE;
            end
            default: begin
                slot     = SLOT_START;
                cur_pend = 1'b0;
                after    = SEQ_IDLE;
            end
        endcase
    end

    assign active   = (state != SEQ_IDLE);
    assign drawdone = ~active;

    // first cycle in a slot that needs drawing
    assign grant     = active && !tft_draw && cur_pend;
    assign start_ack = grant && (slot == SLOT_START);
    assign left_ack  = grant && (slot == SLOT_LEFT);
    assign right_ack = grant && (slot == SLOT_RIGHT);
    assign load      = grant;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state    <= SEQ_IDLE;
            tft_draw <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (draw)
                        state <= SEQ_START;
                end
                default: begin
                    if (tft_draw) begin
                        if (tft_done) begin // window finished
                            tft_draw <= 1'b0;
                            state    <= after;
                        end
                    end else if (cur_pend) begin
                        tft_draw <= 1'b1;
                    end else begin
                        state <= after; // clean, skip
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/gui_pkg.sv
// gui package: coordinate, colour, slot and sequencer types plus the button bitmaps
`default_nettype none

`include "gui_settings.svh"

package gui_pkg;

    typedef logic [`GUI_COORD_W-1:0] coord_t;
    typedef logic [15:0] color_t;

    typedef enum logic [1:0] {
        SLOT_START,
        SLOT_LEFT,
        SLOT_RIGHT
    } slot_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_LEFT,
        SEQ_RIGHT
    } seq_state_t;

    // bit 0 is the upper left pixel, rows run top to bottom
    typedef logic [0:`GUI_BMP_W*`GUI_BMP_H-1] bmp_t;

    // start button while paused, play triangle
    localparam bmp_t BMP_START_PAUSE = {
        20'b00000000000000000000, 20'b00000000000000000000,
        20'b00011000000000000000, 20'b00011110000000000000,
        20'b00011111100000000000, 20'b00011111111000000000,
        20'b00011111111110000000, 20'b00011111111111100000,
        20'b00011111111111111000, 20'b00011111111111111110,
        20'b00011111111111111110, 20'b00011111111111111000,
        20'b00011111111111100000, 20'b00011111111110000000,
        20'b00011111111000000000, 20'b00011111100000000000,
        20'b00011110000000000000, 20'b00011000000000000000,
        20'b00000000000000000000, 20'b00000000000000000000
    };

    // start button while running, two bars
    localparam bmp_t BMP_START_GO = {
        20'b00000000000000000000, 20'b00000000000000000000,
        20'b00001111000011110000, 20'b00001111000011110000,
        20'b00001111000011110000, 20'b00001111000011110000,
        20'b00001111000011110000, 20'b00001111000011110000,
        20'b00001111000011110000, 20'b00001111000011110000,
        20'b00001111000011110000, 20'b00001111000011110000,
        20'b00001111000011110000, 20'b00001111000011110000,
        20'b00001111000011110000, 20'b00001111000011110000,
        20'b00001111000011110000, 20'b00001111000011110000,
        20'b00000000000000000000, 20'b00000000000000000000
    };

    localparam bmp_t BMP_LEFT = {
        20'b00000000000000000000, 20'b00000000000000000000,
        20'b00000001100000000000, 20'b00000011100000000000,
        20'b00000111100000000000, 20'b00001111100000000000,
        20'b00011111111111111100, 20'b00111111111111111100,
        20'b01111111111111111100, 20'b11111111111111111100,
        20'b11111111111111111100, 20'b01111111111111111100,
        20'b00111111111111111100, 20'b00011111111111111100,
        20'b00001111100000000000, 20'b00000111100000000000,
        20'b00000011100000000000, 20'b00000001100000000000,
        20'b00000000000000000000, 20'b00000000000000000000
    };

    // mirror image of the left arrow
    localparam bmp_t BMP_RIGHT = {
        20'b00000000000000000000, 20'b00000000000000000000,
        20'b00000000000110000000, 20'b00000000000111000000,
        20'b00000000000111100000, 20'b00000000000111110000,
        20'b00111111111111111000, 20'b00111111111111111100,
        20'b00111111111111111110, 20'b00111111111111111111,
        20'b00111111111111111111, 20'b00111111111111111110,
        20'b00111111111111111100, 20'b00111111111111111000,
        20'b00000000000111110000, 20'b00000000000111100000,
        20'b00000000000111000000, 20'b00000000000110000000,
        20'b00000000000000000000, 20'b00000000000000000000
    };

endpackage

`default_nettype wire

// File: design/gui_settings.svh
// gui settings: screen geometry, bitmap size and pixel colours of the touch buttons
`ifndef GUI_SETTINGS_SVH
`define GUI_SETTINGS_SVH

// screen coordinates
`define GUI_COORD_W 16

// button bitmap, 1 bit per pixel
`define GUI_BMP_W 20
`define GUI_BMP_H 20

// touch rectangle of every button
`define GUI_BTN_W 40
`define GUI_BTN_H 40

// bitmap corner inside its button
`define GUI_BMP_XOFS 10
`define GUI_BMP_YOFS 10

// all buttons share one column
`define GUI_BTN_X 10

// top edge per button
`define GUI_START_Y 110
`define GUI_LEFT_Y 60
`define GUI_RIGHT_Y 260

// rgb565
`define GUI_FG_COLOR 16'hFFFF // set bit, white
`define GUI_BG_COLOR 16'h0000 // clear bit, black

`endif

// File: src.f
+incdir+design
design/gui_pkg.sv
design/button_touch.sv
design/gui_draw_seq.sv
design/bmp_pixel_stream.sv
design/gui.sv
tb/gui_sva.sv
tb/gui_tb.sv

// File: tb/gui_sva.sv
// gui assertions: idle against drawing, acknowledge and touch pulse rules of the top level
`timescale 1ns/10ps
`default_nettype none

module gui_sva (
    input wire clk,
    input wire arstn,
    input wire drawdone,
    input wire tft_draw,
    input wire start_ack,
    input wire left_ack,
    input wire right_ack,
    input wire left_touched,
    input wire right_touched
);
    int fail_count = 0;

    idle_not_drawing: assert property (@(posedge clk) disable iff (!arstn)
        !(drawdone && tft_draw)) else begin
        $error("drawdone and tft_draw high together");
        fail_count++;
    end

    ack_onehot: assert property (@(posedge clk) disable iff (!arstn)
        $onehot0({start_ack, left_ack, right_ack})) else begin
        $error("more than one acknowledge high");
        fail_count++;
    end

    // touch needs a low cycle before the next press
    left_pulse: assert property (@(posedge clk) disable iff (!arstn)
        left_touched |=> !left_touched) else begin
        $error("left_touched high for more than one cycle");
        fail_count++;
    end

    right_pulse: assert property (@(posedge clk) disable iff (!arstn)
        right_touched |=> !right_touched) else begin
        $error("right_touched high for more than one cycle");
        fail_count++;
    end

    no_ack_idle: assert property (@(posedge clk) disable iff (!arstn)
        drawdone |-> !(start_ack || left_ack || right_ack)) else begin
        $error("acknowledge while the sequencer is idle");
        fail_count++;
    end

endmodule

bind gui gui_sva sva0 (
    .clk(clk), .arstn(arstn), .drawdone(drawdone), .tft_draw(tft_draw),
    .start_ack(start_ack), .left_ack(left_ack), .right_ack(right_ack),
    .left_touched(left_touched), .right_touched(right_touched)
);

`default_nettype wire

// File: tb/gui_tb.sv
// gui testbench: random touches and draw passes checked against a cycle model
`timescale 1ns/10ps
`default_nettype none

`include "gui_settings.svh"

module gui_tb;
    import gui_pkg::*;

    logic   clk;
    logic   arstn;
    logic   touch;
    coord_t touchx;
    coord_t touchy;
    logic   draw;
    logic   cnext;
    logic   tft_done;
    logic   start_rst;
    logic   update;
    logic   tft_draw;
    logic   drawdone;
    coord_t xstart;
    coord_t xend;
    coord_t ystart;
    coord_t yend;
    color_t color;
    logic   start_state;
    logic   left_touched;
    logic   right_touched;

    logic        m_start_state;
    logic [2:0]  m_pend; // start, left, right
    logic [31:0] rng_state;
    int          err_count;
    int          check_count;
    int          test_start;
    int          i;

    gui dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return {16'h0000, rng_state[31:16]};
    endfunction

    function automatic int slot_top(input int s);
        return (s == 0) ? `GUI_START_Y : (s == 1) ? `GUI_LEFT_Y : `GUI_RIGHT_Y;
    endfunction

    function automatic bmp_t slot_bmp(input int s);
        if (s == 0)
            return m_start_state ? BMP_START_GO : BMP_START_PAUSE;
        return (s == 1) ? BMP_LEFT : BMP_RIGHT;
    endfunction

    function automatic logic hit(input int x, input int y, input int top);
        return (x >= `GUI_BTN_X) && (x < `GUI_BTN_X + `GUI_BTN_W) &&
               (y >= top) && (y < top + `GUI_BTN_H);
    endfunction

    task automatic check_coord(input coord_t got, input coord_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_color(input color_t got, input color_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic press(input coord_t x, input coord_t y);
        logic hit_s;
        logic hit_l;
        logic hit_r;
        hit_s = hit(int'(x), int'(y), `GUI_START_Y);
        hit_l = hit(int'(x), int'(y), `GUI_LEFT_Y);
        hit_r = hit(int'(x), int'(y), `GUI_RIGHT_Y);
        @(posedge clk);
        touch  <= 1'b1;
        touchx <= x;
        touchy <= y;
        @(posedge clk);
        touch <= 1'b0; // press seen at this edge
        @(negedge clk);
        if (hit_s) begin
            m_start_state = ~m_start_state;
            m_pend[0]     = 1'b1;
        end
        check_bit(left_touched, hit_l, "left_touched");
        check_bit(right_touched, hit_r, "right_touched");
        check_bit(start_state, m_start_state, "start_state");
        check_bit(update, |m_pend, "update after touch");
        @(negedge clk);
        check_bit(left_touched | right_touched, 1'b0, "touched pulse end");
    endtask

    task automatic random_touch();
        int sel;
        int xi;
        int yi;
        sel = int'(next_rand() % 4);
        xi  = int'(next_rand() % 64);
        if (sel == 3)
            yi = int'(next_rand() % 320); // anywhere on the panel
        else
            yi = slot_top(sel) - 8 + int'(next_rand() % 56); // around one button
        press(coord_t'(xi), coord_t'(yi));
        repeat (int'(next_rand() % 3)) @(posedge clk);
    endtask

    task automatic draw_window(input int s);
        bmp_t exp_bmp;
        int   y0;
        int   n;
        int   k;
        exp_bmp = slot_bmp(s);
        y0      = slot_top(s) + `GUI_BMP_YOFS;
        n       = 0;
        while (tft_draw !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 20)
                stop_on_timeout("tft_draw");
        end
        check_coord(xstart, coord_t'(`GUI_BTN_X + `GUI_BMP_XOFS), "xstart");
        check_coord(xend, coord_t'(`GUI_BTN_X + `GUI_BMP_XOFS + `GUI_BMP_W - 1), "xend");
        check_coord(ystart, coord_t'(y0), "ystart");
        check_coord(yend, coord_t'(y0 + `GUI_BMP_H - 1), "yend");
        for (k = 0; k < `GUI_BMP_W * `GUI_BMP_H; k++) begin
            if (k > 0) begin
                @(posedge clk);
                cnext <= 1'b1;
                @(posedge clk);
                cnext <= 1'b0;
                @(negedge clk);
            end
            check_color(color,
                        exp_bmp[k] ? color_t'(`GUI_FG_COLOR) : color_t'(`GUI_BG_COLOR),
                        $sformatf("pixel %0d of slot %0d", k, s));
        end
        @(posedge clk);
        tft_done <= 1'b1;
        @(posedge clk);
        tft_done <= 1'b0;
        @(negedge clk);
        check_bit(tft_draw, 1'b0, "tft_draw after tft_done");
        m_pend[s] = 1'b0;
    endtask

    task automatic run_pass();
        int s;
        int n;
        @(posedge clk);
        draw <= 1'b1;
        @(posedge clk);
        draw <= 1'b0;
        @(negedge clk);
        check_bit(drawdone, 1'b0, "drawdone after draw");
        for (s = 0; s < 3; s++) begin
            if (m_pend[s])
                draw_window(s);
        end
        n = 0;
        while (drawdone !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 20)
                stop_on_timeout("drawdone at the end of a pass");
        end
        check_bit(update, 1'b0, "update after pass");
        // window outputs read zero while idle
        check_coord(xstart, '0, "xstart in idle");
        check_coord(xend, '0, "xend in idle");
        check_coord(ystart, '0, "ystart in idle");
        check_coord(yend, '0, "yend in idle");
        check_color(color, '0, "color in idle");
    endtask

    initial begin
        rng_state     = 32'd26;
        err_count     = 0;
        check_count   = 0;
        m_start_state = 1'b0;
        m_pend        = 3'b111; // first pass draws everything
        arstn         = 1'b0;
        touch         = 1'b0;
        touchx        = '0;
        touchy        = '0;
        draw          = 1'b0;
        cnext         = 1'b0;
        tft_done      = 1'b0;
        start_rst     = 1'b0;
        repeat (8) @(posedge clk);
        arstn <= 1'b1;
        @(negedge clk);

        test_start = err_count;
        check_bit(drawdone, 1'b1, "drawdone");
        check_bit(tft_draw, 1'b0, "tft_draw");
        check_bit(update, 1'b1, "update");
        check_bit(start_state, 1'b0, "start_state");
        $display("test 1 reset values: %0d errors", err_count - test_start);

        test_start = err_count;
        run_pass();
        $display("test 2 first draw pass: %0d errors", err_count - test_start);

        test_start = err_count;
        for (i = 0; i < 200; i++)
            random_touch();
        $display("test 3 random touches: %0d errors", err_count - test_start);

        test_start = err_count;
        if (|m_pend)
            run_pass();
        press(coord_t'(`GUI_BTN_X + 20), coord_t'(`GUI_START_Y + 20));
        run_pass(); // start window only
        $display("test 4 start toggle redraw: %0d errors", err_count - test_start);

        test_start = err_count;
        if (!m_start_state) begin
            press(coord_t'(`GUI_BTN_X + 20), coord_t'(`GUI_START_Y + 20));
            run_pass();
        end
        @(posedge clk);
        start_rst <= 1'b1;
        @(posedge clk);
        start_rst <= 1'b0;
        @(negedge clk);
        m_start_state = 1'b0;
        m_pend[0]     = 1'b1;
        check_bit(start_state, 1'b0, "start_state after start_rst");
        check_bit(update, 1'b1, "update after start_rst");
        run_pass();
        $display("test 5 start reset redraw: %0d errors", err_count - test_start);

        err_count += dut0.sva0.fail_count;
        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
